//--- logic/dcache_pkg.sv
/*
 Shared widths, address split, FSM encoding and line type of the L1 data cache.
 Geometry is fixed at two ways, 256 sets and 16-byte lines of four 32-bit words.
 Byte offset bits 1:0 are ignored, so only aligned word accesses are supported.
*/
`default_nettype none

package dcache_pkg;

    localparam int addr_w         = 32;
    localparam int word_w         = 32;
    localparam int line_w         = 128;
    localparam int words_per_line = 4;

    localparam int tag_w       = 20;        // addr[31:12]
    localparam int index_w     = 8;         // addr[11:4]
    localparam int offset_w    = 2;         // addr[3:2]
    localparam int tag_entry_w = tag_w + 1; // valid bit on top

    localparam int tag_lsb    = 12;
    localparam int index_lsb  = 4;
    localparam int offset_lsb = 2;

    // one line seen flat for arrays and L2, or as words for select and merge
    typedef union packed {
        logic [line_w-1:0]                     flat;
        logic [words_per_line-1:0][word_w-1:0] words;
    } cache_line_u;

    typedef enum logic [2:0] {
        s_idle         = 3'd0,
        s_access       = 3'd1,
        s_write_hit    = 3'd2,
        s_load_block   = 3'd3,
        s_write_l2     = 3'd4,
        s_wait_l2_busy = 3'd5,
        s_l2_access    = 3'd6,
        s_write_l1     = 3'd7
    } fsm_state_e;

endpackage

`default_nettype wire

//--- logic/way_select.sv
/*
 Tag compare and victim choice for the two ways of the addressed set.
 Purely combinational. Way 0 wins if both ways report a hit.
 lru names the way to replace once both ways are valid.
*/
`timescale 1ns/1ps
`default_nettype none

module way_select import dcache_pkg::*; (
    input  logic [tag_w-1:0]       addr_tag,
    input  logic [tag_entry_w-1:0] tag0_rd,
    input  logic [tag_entry_w-1:0] tag1_rd,
    input  logic                   dirty0,
    input  logic                   dirty1,
    input  logic                   lru,
    output logic                   hit,
    output logic                   hit_way,
    output logic                   victim_way,
    output logic                   victim_dirty
);

    logic valid0;
    logic valid1;
    logic hit0;
    logic hit1;

    assign valid0 = tag0_rd[tag_entry_w-1];
    assign valid1 = tag1_rd[tag_entry_w-1];

    assign hit0 = valid0 && (tag0_rd[tag_w-1:0] == addr_tag);
    assign hit1 = valid1 && (tag1_rd[tag_w-1:0] == addr_tag);

    assign hit     = hit0 || hit1;
    assign hit_way = hit1 && !hit0;  // way 0 has priority

    always_comb begin
        if (!valid0) begin
            victim_way = 1'b0;  // fill empty ways first
        end else if (!valid1) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru;
        end
    end

    // a write-back is only needed for a valid dirty line
    assign victim_dirty = victim_way ? (valid1 && dirty1) : (valid0 && dirty0);

    // a refill always replaces the missing line, so one tag never sits in both ways
    always_comb begin
        assert final ((hit0 & hit1) !== 1'b1)
            else $error("way_select: tag %h present in both ways", addr_tag);
    end

endmodule

`default_nettype wire

//--- logic/line_merge.sv
/*
 Word select and word insert on the line of the way that hit.
 Purely combinational. The outputs only mean something while hit is high.
*/
`timescale 1ns/1ps
`default_nettype none

module line_merge import dcache_pkg::*; (
    input  cache_line_u         data0_rd,
    input  cache_line_u         data1_rd,
    input  logic                hit_way,
    input  logic [offset_w-1:0] offset,
    input  logic [word_w-1:0]   wr_data_m,
    output logic [word_w-1:0]   hit_word,
    output cache_line_u         merged_line
);

    cache_line_u hit_line;

    assign hit_line = hit_way ? data1_rd : data0_rd;

    // read path through the word view
    assign hit_word = hit_line.words[offset];

    always_comb begin
        merged_line                = hit_line;
        merged_line.words[offset]  = wr_data_m;  // other three words kept
    end

endmodule

`default_nettype wire

//--- logic/dcache_fsm.sv
/*
 Control FSM of the L1 data cache. Every output is registered.
 The CPU must hold addr, wr_data_m and memwrite_m until miss_stall falls
 or the read data appears. Each access returns to idle when done.
 A write miss refills first and then finishes as a write hit.
 Victim way is latched at the miss and kept for write-back and refill.
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_fsm import dcache_pkg::*; (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  logic                   access_mem,
    input  logic                   memwrite_m,
    input  logic [addr_w-1:0]      addr,
    input  logic                   hit,
    input  logic                   hit_way,
    input  logic                   victim_way,
    input  logic                   victim_dirty,
    input  logic [word_w-1:0]      hit_word,
    input  cache_line_u            merged_line,
    input  logic [tag_entry_w-1:0] tag0_rd,
    input  logic [tag_entry_w-1:0] tag1_rd,
    input  cache_line_u            data0_rd,
    input  cache_line_u            data1_rd,
    input  logic                   l2_busy,
    input  logic                   l2_rdy,
    input  logic                   l2_complete,
    input  logic                   complete,
    output logic [word_w-1:0]      read_data_m,
    output logic                   miss_stall,
    output logic                   way0_wr,
    output logic                   way1_wr,
    output logic                   dirty_wd,
    output cache_line_u            data_wd_dc,
    output logic                   data_wd_dc_en,
    output logic                   irq,
    output logic [addr_w-1:0]      l2_addr,
    output logic                   l2_cache_rw,
    output cache_line_u            data_rd
);

    fsm_state_e       state;
    logic             victim_q;
    logic [tag_w-1:0] victim_tag;
    cache_line_u      victim_line;

    assign victim_tag  = victim_q ? tag1_rd[tag_w-1:0] : tag0_rd[tag_w-1:0];
    assign victim_line = victim_q ? data1_rd : data0_rd;

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            state         <= s_idle;
            miss_stall    <= 1'b0;
            way0_wr       <= 1'b0;
            way1_wr       <= 1'b0;
            data_wd_dc_en <= 1'b0;
            irq           <= 1'b0;
            l2_cache_rw   <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (access_mem) begin
                        state <= s_access;
                    end
                end
                s_access: begin
                    if (hit) begin
                        miss_stall <= 1'b0;
                        if (memwrite_m) begin
                            way0_wr       <= !hit_way;
                            way1_wr       <= hit_way;
                            dirty_wd      <= 1'b1;
                            data_wd_dc    <= merged_line;
                            data_wd_dc_en <= 1'b1;  // arrays take the CPU line
                            state         <= s_write_hit;
                        end else begin
                            read_data_m <= hit_word;
                            state       <= s_idle;
                        end
                    end else begin
                        miss_stall <= 1'b1;
                        victim_q   <= victim_way;
                        if (victim_dirty) begin
                            state <= s_load_block;
                        end else if (l2_busy) begin
                            state <= s_wait_l2_busy;
                        end else begin
                            irq     <= 1'b1;
                            l2_addr <= addr;
                            state   <= s_l2_access;
                        end
                    end
                end
                s_write_hit: begin
                    if (complete) begin
                        way0_wr       <= 1'b0;
                        way1_wr       <= 1'b0;
                        data_wd_dc_en <= 1'b0;
                        state         <= s_idle;
                    end
                end
                s_load_block: begin
                    // old line address rebuilt from the victim tag
                    data_rd <= victim_line;
                    l2_addr <= {victim_tag, addr[index_lsb +: index_w], {index_lsb{1'b0}}};
                    if (!l2_busy) begin
                        l2_cache_rw <= 1'b1;
                        state       <= s_write_l2;
                    end
                end
                s_write_l2: begin
                    if (l2_complete) begin
                        l2_cache_rw <= 1'b0;
                        l2_addr     <= addr;
                        if (l2_busy) begin
                            state <= s_wait_l2_busy;
                        end else begin
                            irq   <= 1'b1;
                            state <= s_l2_access;
                        end
                    end
                end
                s_wait_l2_busy: begin
                    if (!l2_busy) begin
                        irq     <= 1'b1;
                        l2_addr <= addr;
                        state   <= s_l2_access;
                    end
                end
                s_l2_access: begin
                    if (l2_rdy) begin
                        way0_wr       <= !victim_q;
                        way1_wr       <= victim_q;
                        dirty_wd      <= 1'b0;  // refilled line is clean
                        data_wd_dc_en <= 1'b0;  // arrays take the L2 line
                        state         <= s_write_l1;
                    end
                end
                s_write_l1: begin
                    if (complete) begin
                        way0_wr <= 1'b0;
                        way1_wr <= 1'b0;
                        irq     <= 1'b0;
                        state   <= s_access;  // retry now hits
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // one way is written per array cycle
    assert property (@(posedge clk_tmp) disable iff (!rst_n) !(way0_wr && way1_wr))
        else $error("dcache_fsm: both way strobes high");

    // a refill request never overlaps a write-back to L2
    assert property (@(posedge clk_tmp) disable iff (!rst_n) !(irq && l2_cache_rw))
        else $error("dcache_fsm: irq high during L2 write-back");

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
/*
 Top of the two-way L1 data cache controller.
 Tag, data, dirty and LRU arrays live outside and are read by index.
 way0_wr or way1_wr writes tag, data and dirty of that way together.
 data_wd_dc_en high selects data_wd_dc as the array write data, low the L2 line.
 L2 derives its own set from l2_addr.
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    // cpu side
    input  logic [addr_w-1:0]      addr,
    input  logic [word_w-1:0]      wr_data_m,
    input  logic                   memwrite_m,
    input  logic                   access_mem,
    output logic [word_w-1:0]      read_data_m,
    output logic                   miss_stall,
    // l1 arrays
    output logic [index_w-1:0]     index,
    input  logic                   lru,
    input  logic [tag_entry_w-1:0] tag0_rd,
    input  logic [tag_entry_w-1:0] tag1_rd,
    input  cache_line_u            data0_rd,
    input  cache_line_u            data1_rd,
    input  logic                   dirty0,
    input  logic                   dirty1,
    input  logic                   complete,
    output logic                   way0_wr,
    output logic                   way1_wr,
    output logic [tag_entry_w-1:0] tag_wd,
    output logic                   dirty_wd,
    output cache_line_u            data_wd_dc,
    output logic                   data_wd_dc_en,
    // l2 side
    input  logic                   l2_busy,
    input  logic                   l2_rdy,
    input  logic                   l2_complete,
    output logic                   irq,
    output logic [addr_w-1:0]      l2_addr,
    output logic                   l2_cache_rw,
    output cache_line_u            data_rd
);

    logic [tag_w-1:0]    addr_tag;
    logic [offset_w-1:0] offset;
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_dirty;
    logic [word_w-1:0]   hit_word;
    cache_line_u         merged_line;

    assign addr_tag = addr[tag_lsb +: tag_w];
    assign index    = addr[index_lsb +: index_w];
    assign offset   = addr[offset_lsb +: offset_w];
    assign tag_wd   = {1'b1, addr_tag};  // every written tag is valid

    way_select i_way_select (
        .addr_tag     (addr_tag),
        .tag0_rd      (tag0_rd),
        .tag1_rd      (tag1_rd),
        .dirty0       (dirty0),
        .dirty1       (dirty1),
        .lru          (lru),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty)
    );

    line_merge i_line_merge (
        .data0_rd    (data0_rd),
        .data1_rd    (data1_rd),
        .hit_way     (hit_way),
        .offset      (offset),
        .wr_data_m   (wr_data_m),
        .hit_word    (hit_word),
        .merged_line (merged_line)
    );

    dcache_fsm i_dcache_fsm (
        .clk_tmp       (clk_tmp),
        .rst_n         (rst_n),
        .access_mem    (access_mem),
        .memwrite_m    (memwrite_m),
        .addr          (addr),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .hit_word      (hit_word),
        .merged_line   (merged_line),
        .tag0_rd       (tag0_rd),
        .tag1_rd       (tag1_rd),
        .data0_rd      (data0_rd),
        .data1_rd      (data1_rd),
        .l2_busy       (l2_busy),
        .l2_rdy        (l2_rdy),
        .l2_complete   (l2_complete),
        .complete      (complete),
        .read_data_m   (read_data_m),
        .miss_stall    (miss_stall),
        .way0_wr       (way0_wr),
        .way1_wr       (way1_wr),
        .dirty_wd      (dirty_wd),
        .data_wd_dc    (data_wd_dc),
        .data_wd_dc_en (data_wd_dc_en),
        .irq           (irq),
        .l2_addr       (l2_addr),
        .l2_cache_rw   (l2_cache_rw),
        .data_rd       (data_rd)
    );

endmodule

`default_nettype wire

//--- verification/tb_cache_arrays.sv
/*
 Behavioral L1 tag, data, dirty and LRU arrays plus an L2 responder.
 Each way strobe is answered by one complete pulse a cycle later.
 LRU follows array writes only, so read hits do not move it.
 L2 word at word address w holds w until a write-back overwrites it.
 l2_busy covers two cycles after a request. l2_rdy and l2_complete come three cycles after.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cache_arrays import dcache_pkg::*; (
    input  logic                   clk_tmp,
    input  logic                   rst_n,
    input  logic [index_w-1:0]     index,
    input  logic                   way0_wr,
    input  logic                   way1_wr,
    input  logic [tag_entry_w-1:0] tag_wd,
    input  logic                   dirty_wd,
    input  cache_line_u            data_wd_dc,
    input  logic                   data_wd_dc_en,
    input  logic                   irq,
    input  logic [addr_w-1:0]      l2_addr,
    input  logic                   l2_cache_rw,
    input  cache_line_u            data_rd,
    output logic [tag_entry_w-1:0] tag0_rd,
    output logic [tag_entry_w-1:0] tag1_rd,
    output cache_line_u            data0_rd,
    output cache_line_u            data1_rd,
    output logic                   dirty0,
    output logic                   dirty1,
    output logic                   lru,
    output logic                   complete,
    output logic                   l2_busy,
    output logic                   l2_rdy,
    output logic                   l2_complete,
    output int                     wb_count,
    output logic [addr_w-1:0]      wb_addr,
    output cache_line_u            wb_line
);

    logic [tag_entry_w-1:0] tag_mem   [2][256];
    cache_line_u            line_mem  [2][256];
    logic                   dirty_mem [2][256];
    logic                   lru_mem   [256];
    logic [word_w-1:0]      l2_mem    [logic [29:0]];  // only written-back words
    logic                   wr_en;
    logic                   wr_way;
    logic                   irq_q;
    logic                   rw_q;
    logic [1:0]             busy_cnt;
    logic [1:0]             rdy_cnt;
    logic [1:0]             done_cnt;

    function automatic cache_line_u l2_line(input logic [27:0] line_addr);
        cache_line_u fill;
        logic [29:0] wa;
        for (int w = 0; w < 4; w++) begin
            wa = {line_addr, w[1:0]};
            fill.words[w[1:0]] = l2_mem.exists(wa) ? l2_mem[wa] : {2'b00, wa};
        end
        return fill;
    endfunction

    assign tag0_rd  = tag_mem[0][index];
    assign tag1_rd  = tag_mem[1][index];
    assign data0_rd = line_mem[0][index];
    assign data1_rd = line_mem[1][index];
    assign dirty0   = dirty_mem[0][index];
    assign dirty1   = dirty_mem[1][index];
    assign lru      = lru_mem[index];
    assign wr_en    = (way0_wr || way1_wr) && !complete;  // once per strobe
    assign wr_way   = way1_wr;
    assign l2_busy  = busy_cnt != 2'd0;

    always_ff @(posedge clk_tmp) begin
        if (!rst_n) begin
            for (int s = 0; s < 256; s++) begin
                tag_mem[0][s[7:0]]   <= '0;  // valid bit cleared
                tag_mem[1][s[7:0]]   <= '0;
                dirty_mem[0][s[7:0]] <= 1'b0;
                dirty_mem[1][s[7:0]] <= 1'b0;
                lru_mem[s[7:0]]      <= 1'b0;
            end
            complete    <= 1'b0;
            irq_q       <= 1'b0;
            rw_q        <= 1'b0;
            busy_cnt    <= 2'd0;
            rdy_cnt     <= 2'd0;
            done_cnt    <= 2'd0;
            l2_rdy      <= 1'b0;
            l2_complete <= 1'b0;
            wb_count    <= 0;
        end else begin
            irq_q    <= irq;
            rw_q     <= l2_cache_rw;
            complete <= wr_en;
            if (wr_en) begin
                tag_mem[wr_way][index]   <= tag_wd;
                dirty_mem[wr_way][index] <= dirty_wd;
                line_mem[wr_way][index]  <= data_wd_dc_en ? data_wd_dc : l2_line(l2_addr[31:4]);
                lru_mem[index]           <= !wr_way;  // other way is now older
            end
            if ((irq && !irq_q) || (l2_cache_rw && !rw_q)) begin
                busy_cnt <= 2'd2;
            end else if (busy_cnt != 2'd0) begin
                busy_cnt <= busy_cnt - 2'd1;
            end
            if (irq && !irq_q) begin
                rdy_cnt <= 2'd3;
            end else if (rdy_cnt != 2'd0) begin
                rdy_cnt <= rdy_cnt - 2'd1;
            end
            if (l2_cache_rw && !rw_q) begin
                done_cnt <= 2'd3;
                wb_count <= wb_count + 1;
                wb_addr  <= l2_addr;  // recorded at the start of the write-back
                wb_line  <= data_rd;
            end else if (done_cnt != 2'd0) begin
                done_cnt <= done_cnt - 2'd1;
            end
            l2_rdy      <= rdy_cnt == 2'd1;
            l2_complete <= done_cnt == 2'd1;
        end
    end

    // L2 takes the victim line when the write-back starts
    always @(posedge clk_tmp) begin
        if (rst_n && l2_cache_rw && !rw_q) begin
            for (int w = 0; w < 4; w++) begin
                l2_mem[{l2_addr[31:4], w[1:0]}] = data_rd.words[w[1:0]];
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_dcache_ctrl.sv
/*
 Testbench for dcache_ctrl. Vectors are read from verification/dcache_input.txt,
 so the simulation must start in the project root.
 Read data is checked against the file and against a golden word memory that
 starts at address/4 and follows every CPU write.
 The watchdog allows 40 cycles per vector plus reset.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_ctrl import dcache_pkg::*; ();

    logic                   clk_tmp;
    logic                   rst_n;
    logic [addr_w-1:0]      addr;
    logic [word_w-1:0]      wr_data_m;
    logic                   memwrite_m;
    logic                   access_mem;
    logic [word_w-1:0]      read_data_m;
    logic                   miss_stall;
    logic [index_w-1:0]     index;
    logic                   lru;
    logic [tag_entry_w-1:0] tag0_rd;
    logic [tag_entry_w-1:0] tag1_rd;
    cache_line_u            data0_rd;
    cache_line_u            data1_rd;
    logic                   dirty0;
    logic                   dirty1;
    logic                   complete;
    logic                   way0_wr;
    logic                   way1_wr;
    logic [tag_entry_w-1:0] tag_wd;
    logic                   dirty_wd;
    cache_line_u            data_wd_dc;
    logic                   data_wd_dc_en;
    logic                   l2_busy;
    logic                   l2_rdy;
    logic                   l2_complete;
    logic                   irq;
    logic [addr_w-1:0]      l2_addr;
    logic                   l2_cache_rw;
    cache_line_u            data_rd;
    int                     wb_count;
    logic [addr_w-1:0]      wb_addr;
    cache_line_u            wb_line;

    logic [3:0]             vec_op   [$];
    logic [addr_w-1:0]      vec_addr [$];
    logic [word_w-1:0]      vec_wd   [$];
    logic [word_w-1:0]      vec_exp  [$];
    logic [word_w-1:0]      golden   [logic [29:0]];  // CPU-written words only
    int                     n_vec;
    int                     error_count;
    int                     check_count;
    logic                   loaded;

    dcache_ctrl i_dut (.*);

    tb_cache_arrays i_arrays (.*);

    initial begin
        clk_tmp = 1'b0;
        forever #50 clk_tmp = ~clk_tmp;  // 100 ns period
    end

    function automatic logic [word_w-1:0] golden_word(input logic [29:0] wa);
        if (golden.exists(wa)) begin
            return golden[wa];
        end
        return {2'b00, wa};
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] expected);
        check_count++;
        assert (got === expected) else begin
            error_count++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       text;
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] wd;
        logic [31:0] ex;
        fd = $fopen("verification/dcache_input.txt", "r");
        assert (fd != 0) else begin
            error_count++;
            $display("could not open the vector file verification/dcache_input.txt");
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code != 0 && $sscanf(text, "%h %h %h %h", op, a, wd, ex) == 4) begin
                    vec_op.push_back(op);  // comment lines give no match
                    vec_addr.push_back(a);
                    vec_wd.push_back(wd);
                    vec_exp.push_back(ex);
                end
            end
            $fclose(fd);
        end
        n_vec  = vec_op.size();
        loaded = 1'b1;
    endtask

    task automatic check_reset();
        @(negedge clk_tmp);
        compare_value("miss_stall", 128'(miss_stall), 128'(0));
        compare_value("irq", 128'(irq), 128'(0));
        compare_value("way0_wr", 128'(way0_wr), 128'(0));
        compare_value("way1_wr", 128'(way1_wr), 128'(0));
        compare_value("data_wd_dc_en", 128'(data_wd_dc_en), 128'(0));
        compare_value("l2_cache_rw", 128'(l2_cache_rw), 128'(0));
    endtask

    // op bit 2 is write, bits 1:0 the expected path (0 hit, 1 clean miss, 2 dirty miss)
    task automatic run_access(input int v);
        logic              is_write;
        logic [1:0]        kind;
        logic              missed;
        logic              irq_seen;
        logic [addr_w-1:0] irq_addr;
        logic [addr_w-1:0] a;
        int                wb_before;
        cache_line_u       gold_line;
        a         = vec_addr[v];
        is_write  = vec_op[v][2];
        kind      = vec_op[v][1:0];
        missed    = 1'b0;
        irq_seen  = 1'b0;
        irq_addr  = '0;
        wb_before = wb_count;
        @(posedge clk_tmp);
        #5;
        addr       = a;
        wr_data_m  = vec_wd[v];
        memwrite_m = is_write;
        access_mem = 1'b1;
        @(posedge clk_tmp);
        #5;
        access_mem = 1'b0;
        compare_value("miss_stall", 128'(miss_stall), 128'(0));  // never before the second edge
        @(posedge clk_tmp);  // second edge decides hit or miss
        @(negedge clk_tmp);
        while (miss_stall) begin
            missed = 1'b1;
            if (irq && !irq_seen) begin
                irq_seen = 1'b1;
                irq_addr = l2_addr;
            end
            if ((way0_wr || way1_wr) && !data_wd_dc_en) begin
                compare_value("dirty_wd", 128'(dirty_wd), 128'(0));  // refill is clean
            end
            @(negedge clk_tmp);
        end
        compare_value("index", 128'(index), 128'(a[11:4]));
        compare_value("miss_stall", 128'(missed), 128'(kind != 2'd0));
        if (missed) begin
            compare_value("irq", 128'(irq_seen), 128'(1));
            compare_value("l2_addr", 128'(irq_addr), 128'(a));
        end
        compare_value("write-back count", 128'(wb_count - wb_before), 128'(kind == 2'd2));
        if (kind == 2'd2) begin
            for (int w = 0; w < 4; w++) begin
                gold_line.words[w[1:0]] = golden_word({wb_addr[31:4], w[1:0]});
            end
            compare_value("data_rd", 128'(wb_line), 128'(gold_line));
            if (!is_write) begin
                compare_value("l2_addr", 128'(wb_addr), 128'(vec_wd[v]));  // victim line address
            end
        end
        if (is_write) begin
            for (int w = 0; w < 4; w++) begin
                gold_line.words[w[1:0]] = golden_word({a[31:4], w[1:0]});
            end
            gold_line.words[a[3:2]] = vec_wd[v];
            compare_value("way write strobe", 128'(way0_wr || way1_wr), 128'(1));
            compare_value("data_wd_dc_en", 128'(data_wd_dc_en), 128'(1));
            compare_value("dirty_wd", 128'(dirty_wd), 128'(1));
            compare_value("tag_wd", 128'(tag_wd), 128'({1'b1, a[31:12]}));
            compare_value("data_wd_dc", 128'(data_wd_dc), 128'(gold_line));
            while (way0_wr || way1_wr) begin
                @(negedge clk_tmp);
            end
            golden[a[31:2]] = vec_wd[v];
        end else begin
            compare_value("read_data_m", 128'(read_data_m), 128'(golden_word(a[31:2])));
            compare_value("read_data_m", 128'(read_data_m), 128'(vec_exp[v]));
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        access_mem  = 1'b0;
        memwrite_m  = 1'b0;
        addr        = '0;
        wr_data_m   = '0;
        error_count = 0;
        check_count = 0;
        n_vec       = 0;
        loaded      = 1'b0;
        load_vectors();
        repeat (4) @(posedge clk_tmp);
        #5;
        rst_n = 1'b1;
        check_reset();
        for (int v = 0; v < n_vec; v++) begin
            run_access(v);
        end
        $display("%0d vectors, %0d checks, %0d errors", n_vec, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((n_vec * 40 + 20) * 100);
        $display("watchdog expired before all %0d vectors finished", n_vec);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dcache_input.txt
# columns: op addr wdata rdata, all hex
# op bit 2 write, bits 1:0 path (0 hit, 1 clean miss, 2 dirty miss); dirty-miss reads give
# the expected write-back line address in wdata
1 00000040 00000000 00000010  # cold miss fills way 0
0 00000044 00000000 00000011
4 00000048 deadbeef 00000000  # dirties way 0
0 00000048 00000000 deadbeef
0 0000004c 00000000 00000013
0 00000040 00000000 00000010
1 00001040 00000000 00000410  # fills way 1
2 00002048 00000040 00000812  # lru names dirty way 0
0 00001044 00000000 00000411  # survivor still hits
1 00000048 00000000 deadbeef  # reload from written-back line
0 00002040 00000000 00000810
4 00000044 cafef00d 00000000  # dirties way 1
1 00001040 00000000 00000410  # clean way 0 replaced
2 0000204c 00000040 00000813  # way 1 written back
0 00001048 00000000 00000412
1 00000044 00000000 cafef00d
0 00000040 00000000 00000010
0 00000048 00000000 deadbeef
5 00000104 12345678 00000000  # write miss then write hit
0 00000104 00000000 12345678
0 00000100 00000000 00000040
0 0000010c 00000000 00000043
1 fff00208 00000000 3ffc0082
0 fff0020c 00000000 3ffc0083

//--- sources.f
logic/dcache_pkg.sv
logic/way_select.sv
logic/line_merge.sv
logic/dcache_fsm.sv
logic/dcache_ctrl.sv
verification/tb_cache_arrays.sv
verification/tb_dcache_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dcache_ctrl testbench with Verilator from the project root.
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_dcache_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF 'All tests passed!' "$log"; then
    exit 0
fi
exit 1
